//--- test/link_ctrl_input.txt
// columns (hex): action addr wdata expected mode stall
// action below 100 is the request command, 100 mode, 101 probe, 102 window, 103 counter
001 00000000 00000000 00000000 0 0 // reset values
001 00000004 00000000 00000000 0 0
001 00000008 00000000 00000000 0 0
001 0000000c 00000000 00000000 0 0
001 00000010 00000000 00000000 0 0
001 00000014 00000000 00000010 0 0 // interval default 16
001 00000018 00000000 00000000 0 0
001 00000024 00000000 00000000 0 0
001 00000028 00000000 00000000 0 0 // unmapped
001 000000fc 00000000 00000000 0 0
101 00000006 00000000 00000000 0 0 // link flags
003 00000000 000000a5 00000000 0 2 // ctrl
001 00000000 00000000 000000a5 0 0
101 00000000 00000000 00000002 0 0 // arbmode
003 00000008 00370011 00000000 0 0 // txmode
001 00000008 00000000 00370011 0 0
101 00000001 00000000 00000037 0 0
003 0000000c 00290001 00000000 0 0 // rxmode
001 0000000c 00000000 00290001 0 0
101 00000002 00000000 00000029 0 0
003 00000010 00200008 00000000 0 0 // crdtinit
001 00000010 00000000 00200008 0 0
101 00000004 00000000 00000008 0 0
101 00000005 00000000 00000020 0 0
003 00000014 12345678 00000000 0 4 // interval, low half only
001 00000014 00000000 00005678 0 3
101 00000003 00000000 00005678 0 0
003 00000004 ffffffff 00000000 0 0 // status is read only
001 00000004 00000000 00000000 0 0
005 00000000 ffffffff 00000000 0 1 // unknown opcode
003 01000008 ffffffff 00000000 0 0 // wrong group write
001 80000014 00000000 00000000 0 0 // wrong group read
001 00000000 00000000 000000a5 0 0
001 00000008 00000000 00370011 0 0
100 00000000 00000000 00000000 00010102 0 // device, not ready, phy up
101 00000006 00000000 00000001 0 0
001 00000004 00000000 00000000 0 0
100 00000000 00000000 00000000 00011102 0 // device ready
101 00000006 00000000 0000000f 0 0
001 00000004 00000000 00000010 0 0
001 00000008 00000000 00020011 0 0
001 0000000c 00000000 00020001 0 0
001 00000010 00000000 00100010 0 0
100 00000000 00000000 00000000 00000000 0 // host, phy down
101 00000006 00000000 00000001 0 0
100 00000000 00000000 00000000 00000103 0 // host, phy up, width 3
101 00000006 00000000 0000000f 0 0
101 00000001 00000000 00000003 0 0
001 00000010 00000000 00080008 0 0
102 00000080 00000000 00000000 0 0 // lfsr window
103 00000018 00000000 00000000 0 0
103 0000001c 00000000 00000000 0 0
103 00000020 00000000 00000000 0 0
103 00000024 00000000 00000000 0 2
1ff 00000000 00000000 00000000 0 0

//--- files.f
design/link_pkg.sv
design/link_req_decode.sv
design/link_csr.sv
design/link_resp_build.sv
design/link_crdt_monitor.sv
design/link_ctrl_top.sv
test/link_ctrl_props.sv
test/link_ctrl_tb.sv

//--- test/link_ctrl_tb.sv
/*
 * testbench for the link control top
 * file driven requests, mode changes, output probes, lfsr credit window
 */
`timescale 1ns/1ps

module link_ctrl_tb;

   import link_pkg::*;

   localparam int max_lines = 64;                // six words per line

   logic        clk;
   logic        nreset;
   logic        devicemode, deviceready, phy_linkactive;
   logic [7:0]  phy_iow;
   logic        req_valid, req_ready, resp_valid, resp_ready;
   logic [31:0] req_cmd, req_addr, req_data, resp_cmd, resp_addr, resp_data;
   logic        req_pending, req_crdt_avail, resp_pending, resp_crdt_avail;
   logic        host_linkactive, csr_txen, csr_txcrdt_en, csr_rxen;
   logic [1:0]  csr_arbmode;
   logic [7:0]  csr_txiowidth, csr_rxiowidth;
   logic [15:0] csr_txcrdt_intrvl, csr_rxcrdt_req_init, csr_rxcrdt_resp_init;

   logic [31:0] vec [max_lines*6];
   logic [31:0] tally [4];                       // req/resp stall, req/resp active
   logic [31:0] lfsr = 32'h5239;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          cycle_limit = 100000;            // replaced once the file is read
   int          n_lines;
   int          window;

   link_ctrl_top UUT (.*);

   always #2 clk = ~clk;                         // 4 ns period

   // run limit
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("timeout: no progress after %0d cycles", cycles);
         $display("tests failed");
         $finish;
      end
   end

   //######################################################################
   // helpers
   //######################################################################
   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);   // galois taps
   endfunction

   // response code by the decode rules
   function automatic logic [31:0] expected_code(input logic [31:0] op, input logic [31:0] addr);
      expected_code = {27'd0, resp_error};
      if (addr[31:24] == 8'h00 && op[4:0] == req_read)
         expected_code = {27'd0, resp_read};
      if (addr[31:24] == 8'h00 && op[4:0] == req_write)
         expected_code = {27'd0, resp_write};
   endfunction

   function automatic logic [31:0] probe(input logic [2:0] sel);
      case (sel)
         3'd0    : probe = csr_arbmode;
         3'd1    : probe = csr_txiowidth;
         3'd2    : probe = csr_rxiowidth;
         3'd3    : probe = csr_txcrdt_intrvl;
         3'd4    : probe = csr_rxcrdt_req_init;
         3'd5    : probe = csr_rxcrdt_resp_init;
         3'd6    : probe = {host_linkactive, csr_txen, csr_rxen, csr_txcrdt_en};
         default : probe = '0;
      endcase
   endfunction

   task automatic run_request(input logic [31:0] cmd, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp_data,
                              input logic [31:0] stall);
      logic [31:0] got_cmd, got_addr, got_data;
      @(posedge clk);
      req_valid <= 1'b1;
      req_cmd   <= cmd;
      req_addr  <= addr;
      req_data  <= wdata;
      @(negedge clk);
      while (!req_ready)
         @(negedge clk);
      @(posedge clk);                            // accepted here
      req_valid <= 1'b0;
      @(negedge clk);
      while (!resp_valid)
         @(negedge clk);
      got_cmd  = resp_cmd;
      got_addr = resp_addr;
      got_data = resp_data;
      for (int i = 0; i < stall; i++)            // back-pressure
      begin
         @(negedge clk);
         compare(resp_valid, 1'b1, "resp_valid held");
         compare(resp_cmd, got_cmd, "held resp_cmd");
         compare(resp_data, got_data, "held resp_data");
         compare(req_ready, 1'b0, "req_ready while stalled");
      end
      @(posedge clk);
      resp_ready <= 1'b1;
      @(posedge clk);                            // taken here
      resp_ready <= 1'b0;
      compare(got_cmd, expected_code(cmd, addr), "response code");
      compare(got_addr, addr, "echoed address");
      compare(got_data, exp_data, "response data");
   endtask

   // random pending and credit bits tallied as driven
   task automatic count_window(input int n);
      logic [3:0] b;
      for (int i = 0; i < n; i++)
      begin
         for (int k = 0; k < 4; k++)
         begin
            lfsr = lfsr_step(lfsr);
            b[k] = lfsr[0];
         end
         @(posedge clk);
         req_pending     <= b[0];
         req_crdt_avail  <= b[1];
         resp_pending    <= b[2];
         resp_crdt_avail <= b[3];
         tally[0] = tally[0] + (b[0] & ~b[1]);
         tally[1] = tally[1] + (b[2] & ~b[3]);
         tally[2] = tally[2] + (b[0] & b[1]);
         tally[3] = tally[3] + (b[2] & b[3]);
      end
      @(posedge clk);
      req_pending  <= 1'b0;
      resp_pending <= 1'b0;
   endtask

   task automatic run_line(input int l);
      logic [31:0] act, addr, mode;
      act  = vec[6*l];
      addr = vec[6*l+1];
      mode = vec[6*l+4];
      if (act < 32'h100)                         // plain request with the action as command
         run_request(act, addr, vec[6*l+2], vec[6*l+3], vec[6*l+5]);
      else if (act == 32'h100)
      begin
         @(posedge clk);
         devicemode     <= mode[16];
         deviceready    <= mode[12];
         phy_linkactive <= mode[8];
         phy_iow        <= mode[7:0];
         repeat (6) @(posedge clk);              // qualify, rise, load
      end
      else if (act == 32'h101)
      begin
         @(negedge clk);
         compare(probe(addr[2:0]), vec[6*l+3], "output probe");
      end
      else if (act == 32'h102)
         count_window(addr);
      else if (act == 32'h103)
         run_request({27'd0, req_read}, addr, '0, tally[addr[7:2]-6], vec[6*l+5]);
      else
      begin
         errors++;
         $display("unknown action %h on data line %0d", act, l);
      end
   endtask

   //######################################################################
   // main sequence
   //######################################################################
   initial
   begin
      clk = 1'b0;
      nreset = 1'b0;
      devicemode = 1'b0;
      deviceready = 1'b0;
      phy_linkactive = 1'b0;
      phy_iow = 8'h00;
      req_valid = 1'b0;
      req_cmd = '0;
      req_addr = '0;
      req_data = '0;
      resp_ready = 1'b0;
      req_pending = 1'b0;
      req_crdt_avail = 1'b0;
      resp_pending = 1'b0;
      resp_crdt_avail = 1'b0;
      for (int i = 0; i < 4; i++)
         tally[i] = '0;
      $readmemh("test/link_ctrl_input.txt", vec);
      n_lines = 0;
      window  = 0;
      while (n_lines < max_lines && vec[6*n_lines] !== 32'h1ff)
      begin
         if (vec[6*n_lines] === 32'h102)
            window = window + vec[6*n_lines+1];
         n_lines++;
      end
      if (n_lines == max_lines)
      begin
         errors++;
         $display("input file missing or has no end line");
      end
      cycle_limit = 5 + 60 * n_lines + window + 20;
      repeat (5) @(posedge clk);
      nreset <= 1'b1;
      for (int l = 0; l < n_lines && l < max_lines; l++)
         run_line(l);
      repeat (2) @(posedge clk);
      errors = errors + UUT.u_props.fail_count;  // bound assertion failures
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

//--- test/link_ctrl_props.sv
/*
 * bound checks on the link control top
 * response hold under back-pressure, channel exclusion, strobe exclusion
 */
`timescale 1ns/1ps

module link_ctrl_props
  (
   input logic                         clk,
   input logic                         nreset,
   input logic                         req_ready,
   input logic                         resp_valid,
   input logic                         resp_ready,
   input logic [link_pkg::link_cw-1:0] resp_cmd,
   input logic [link_pkg::link_aw-1:0] resp_addr,
   input logic [link_pkg::link_rw-1:0] resp_data,
   input logic                         csr_write,
   input logic                         csr_read
   );

   int fail_count = 0;                           // failed assertions so far

   // response held and stable until taken
   a_resp_hold : assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_cmd)
                                    && $stable(resp_addr) && $stable(resp_data))
      else
      begin
         fail_count++;
         $error("response dropped or changed under back-pressure");
      end

   // single item in flight
   a_one_item : assert property (@(posedge clk) disable iff (!nreset)
      !(req_ready && resp_valid))
      else
      begin
         fail_count++;
         $error("req_ready high while a response is pending");
      end

   a_one_strobe : assert property (@(posedge clk) disable iff (!nreset)
      !(csr_write && csr_read))
      else
      begin
         fail_count++;
         $error("csr read and write strobes overlap");
      end

endmodule

bind link_ctrl_top link_ctrl_props u_props
  (.clk        (clk),
   .nreset     (nreset),
   .req_ready  (req_ready),
   .resp_valid (resp_valid),
   .resp_ready (resp_ready),
   .resp_cmd   (resp_cmd),
   .resp_addr  (resp_addr),
   .resp_data  (resp_data),
   .csr_write  (csr_write),
   .csr_read   (csr_read));

//--- design/link_ctrl_top.sv
/*
 * link control block top
 * decode, register bank, credit monitor, response builder
 */
`timescale 1ns/1ps

module link_ctrl_top
  (
   input  logic                         clk,
   input  logic                         nreset,
   input  logic                         devicemode,
   input  logic                         deviceready,
   input  logic                         phy_linkactive,
   input  logic [7:0]                   phy_iow,
   // request channel
   input  logic                         req_valid,
   input  logic [link_pkg::link_cw-1:0] req_cmd,
   input  logic [link_pkg::link_aw-1:0] req_addr,
   input  logic [link_pkg::link_rw-1:0] req_data,
   output logic                         req_ready,
   // response channel
   output logic                         resp_valid,
   output logic [link_pkg::link_cw-1:0] resp_cmd,
   output logic [link_pkg::link_aw-1:0] resp_addr,
   output logic [link_pkg::link_rw-1:0] resp_data,
   input  logic                         resp_ready,
   // credit monitor inputs
   input  logic                         req_pending,
   input  logic                         req_crdt_avail,
   input  logic                         resp_pending,
   input  logic                         resp_crdt_avail,
   // link controls
   output logic                         host_linkactive,
   output logic [1:0]                   csr_arbmode,
   output logic                         csr_txen,
   output logic                         csr_txcrdt_en,
   output logic [7:0]                   csr_txiowidth,
   output logic                         csr_rxen,
   output logic [7:0]                   csr_rxiowidth,
   output logic [15:0]                  csr_txcrdt_intrvl,
   output logic [15:0]                  csr_rxcrdt_req_init,
   output logic [15:0]                  csr_rxcrdt_resp_init
   );

   import link_pkg::*;

   logic               csr_write;
   logic               csr_read;
   logic [5:0]         csr_offset;
   logic [link_rw-1:0] csr_rddata;
   logic               exec_valid;
   link_opcode_e       exec_opcode;
   logic [link_aw-1:0] exec_addr;
   logic               resp_done;
   logic [31:0]        req_stall_cycles;
   logic [31:0]        resp_stall_cycles;
   logic [31:0]        req_active_cycles;
   logic [31:0]        resp_active_cycles;

   link_req_decode u_decode
     (.clk         (clk),
      .nreset      (nreset),
      .req_valid   (req_valid),
      .req_cmd     (req_cmd),
      .req_addr    (req_addr),
      .req_ready   (req_ready),
      .csr_write   (csr_write),
      .csr_read    (csr_read),
      .csr_offset  (csr_offset),
      .exec_valid  (exec_valid),
      .exec_opcode (exec_opcode),
      .exec_addr   (exec_addr),
      .resp_done   (resp_done));

   // write data straight from the host, stable until accept
   link_csr u_csr
     (.clk                  (clk),
      .nreset               (nreset),
      .devicemode           (devicemode),
      .deviceready          (deviceready),
      .phy_linkactive       (phy_linkactive),
      .phy_iow              (phy_iow),
      .csr_write            (csr_write),
      .csr_read             (csr_read),
      .csr_offset           (csr_offset),
      .csr_wrdata           (req_data),
      .csr_rddata           (csr_rddata),
      .req_stall_cycles     (req_stall_cycles),
      .resp_stall_cycles    (resp_stall_cycles),
      .req_active_cycles    (req_active_cycles),
      .resp_active_cycles   (resp_active_cycles),
      .host_linkactive      (host_linkactive),
      .csr_arbmode          (csr_arbmode),
      .csr_txen             (csr_txen),
      .csr_txcrdt_en        (csr_txcrdt_en),
      .csr_txiowidth        (csr_txiowidth),
      .csr_rxen             (csr_rxen),
      .csr_rxiowidth        (csr_rxiowidth),
      .csr_txcrdt_intrvl    (csr_txcrdt_intrvl),
      .csr_rxcrdt_req_init  (csr_rxcrdt_req_init),
      .csr_rxcrdt_resp_init (csr_rxcrdt_resp_init));

   link_crdt_monitor u_monitor
     (.clk                (clk),
      .nreset             (nreset),
      .req_pending        (req_pending),
      .req_crdt_avail     (req_crdt_avail),
      .resp_pending       (resp_pending),
      .resp_crdt_avail    (resp_crdt_avail),
      .req_stall_cycles   (req_stall_cycles),
      .resp_stall_cycles  (resp_stall_cycles),
      .req_active_cycles  (req_active_cycles),
      .resp_active_cycles (resp_active_cycles));

   link_resp_build u_resp
     (.clk         (clk),
      .nreset      (nreset),
      .exec_valid  (exec_valid),
      .exec_opcode (exec_opcode),
      .exec_addr   (exec_addr),
      .csr_rddata  (csr_rddata),
      .resp_valid  (resp_valid),
      .resp_cmd    (resp_cmd),
      .resp_addr   (resp_addr),
      .resp_data   (resp_data),
      .resp_ready  (resp_ready),
      .resp_done   (resp_done));

endmodule

//--- design/link_crdt_monitor.sv
/*
 * credit monitor
 * saturating stall and active cycle counters for req and resp
 */
`timescale 1ns/1ps

module link_crdt_monitor
  (
   input  logic        clk,
   input  logic        nreset,
   input  logic        req_pending,
   input  logic        req_crdt_avail,
   input  logic        resp_pending,
   input  logic        resp_crdt_avail,
   output logic [31:0] req_stall_cycles,
   output logic [31:0] resp_stall_cycles,
   output logic [31:0] req_active_cycles,
   output logic [31:0] resp_active_cycles
   );

   import link_pkg::*;

   logic [3:0]         hit;                      // count enables
   logic [link_rw-1:0] cnt [4];

   // 0 req stall, 1 resp stall, 2 req active, 3 resp active
   assign hit = {resp_pending & resp_crdt_avail,
                 req_pending & req_crdt_avail,
                 resp_pending & ~resp_crdt_avail,
                 req_pending & ~req_crdt_avail};

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < 4; i++)
            cnt[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < 4; i++)
            if (hit[i] && !(&cnt[i]))            // stop at all ones
               cnt[i] <= cnt[i] + 1'b1;
      end
   end

   assign req_stall_cycles   = cnt[0];
   assign resp_stall_cycles  = cnt[1];
   assign req_active_cycles  = cnt[2];
   assign resp_active_cycles = cnt[3];

endmodule

//--- design/link_resp_build.sv
/*
 * response builder
 * maps request opcode to response code, holds under back-pressure
 */
`timescale 1ns/1ps

module link_resp_build
  (
   input  logic                         clk,
   input  logic                         nreset,
   // from decode and csr
   input  logic                         exec_valid,
   input  link_pkg::link_opcode_e       exec_opcode,
   input  logic [link_pkg::link_aw-1:0] exec_addr,
   input  logic [link_pkg::link_rw-1:0] csr_rddata,
   // host response channel
   output logic                         resp_valid,
   output logic [link_pkg::link_cw-1:0] resp_cmd,
   output logic [link_pkg::link_aw-1:0] resp_addr,
   output logic [link_pkg::link_rw-1:0] resp_data,
   input  logic                         resp_ready,
   output logic                         resp_done
   );

   import link_pkg::*;

   logic               pend_q;                   // read data lands this cycle
   link_opcode_e       op_q;
   logic [link_aw-1:0] addr_q;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         pend_q     <= 1'b0;
         resp_valid <= 1'b0;
      end
      else
      begin
         pend_q     <= exec_valid;
         resp_valid <= pend_q | (resp_valid & ~resp_ready);  // hold until taken
      end
   end

   always_ff @(posedge clk)
   begin
      if (exec_valid)
      begin
         op_q   <= exec_opcode;
         addr_q <= exec_addr;
      end
   end

   // payload loads once, stays put while valid
   always_ff @(posedge clk)
   begin
      if (pend_q)
      begin
         resp_addr <= addr_q;                    // echo
         case (op_q)
            req_read :
            begin
               resp_cmd  <= {{(link_cw-5){1'b0}}, resp_read};
               resp_data <= csr_rddata;
            end
            req_write :
            begin
               resp_cmd  <= {{(link_cw-5){1'b0}}, resp_write};
               resp_data <= '0;
            end
            default :
            begin
               resp_cmd  <= {{(link_cw-5){1'b0}}, resp_error};
               resp_data <= '0;
            end
         endcase
      end
   end

   assign resp_done = resp_valid & resp_ready;

endmodule

//--- design/link_csr.sv
/*
 * link control register bank
 * link-active qualify, auto-load on link rise, field outputs, read mux
 */
`timescale 1ns/1ps

module link_csr
  (
   input  logic                         clk,
   input  logic                         nreset,
   // mode and phy status
   input  logic                         devicemode,   // 1 = device, 0 = host
   input  logic                         deviceready,
   input  logic                         phy_linkactive,
   input  logic [7:0]                   phy_iow,
   // register access
   input  logic                         csr_write,
   input  logic                         csr_read,
   input  logic [5:0]                   csr_offset,
   input  logic [link_pkg::link_rw-1:0] csr_wrdata,
   output logic [link_pkg::link_rw-1:0] csr_rddata,
   // perf counters from the monitor
   input  logic [31:0]                  req_stall_cycles,
   input  logic [31:0]                  resp_stall_cycles,
   input  logic [31:0]                  req_active_cycles,
   input  logic [31:0]                  resp_active_cycles,
   // control outputs
   output logic                         host_linkactive,
   output logic [1:0]                   csr_arbmode,
   output logic                         csr_txen,
   output logic                         csr_txcrdt_en,
   output logic [7:0]                   csr_txiowidth,
   output logic                         csr_rxen,
   output logic [7:0]                   csr_rxiowidth,
   output logic [15:0]                  csr_txcrdt_intrvl,
   output logic [15:0]                  csr_rxcrdt_req_init,
   output logic [15:0]                  csr_rxcrdt_resp_init
   );

   import link_pkg::*;

   logic [link_rw-1:0] ctrl_reg;
   logic [link_rw-1:0] status_reg;
   logic [link_rw-1:0] txmode_reg;
   logic [link_rw-1:0] rxmode_reg;
   logic [31:0]        crdtinit_reg;             // resp count high, req low
   logic [15:0]        intrvl_reg;
   logic               linkactive;
   logic               linkactive_d;
   logic               linkactive_rise;

   //####################################################################
   // link active
   //####################################################################
   // a device must also be ready, a host follows the phy alone
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         linkactive <= 1'b0;
      else if (deviceready || !devicemode)
         linkactive <= phy_linkactive;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         linkactive_d    <= 1'b0;
         linkactive_rise <= 1'b0;
      end
      else
      begin
         linkactive_d    <= linkactive;
         linkactive_rise <= linkactive & ~linkactive_d;  // one-cycle pulse
      end
   end

   assign host_linkactive = linkactive;

   //####################################################################
   // registers
   //####################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         ctrl_reg     <= '0;
         status_reg   <= '0;
         txmode_reg   <= '0;
         rxmode_reg   <= '0;
         crdtinit_reg <= '0;
         intrvl_reg   <= 16'h0010;               // default update interval
      end
      else
      begin
         // status is read only, bit 4 mirrors link active
         status_reg <= {{(link_rw-5){1'b0}}, linkactive, 4'h0};
         if (csr_write && csr_offset == ctrl)
            ctrl_reg <= csr_wrdata;
         if (csr_write && csr_offset == crdtintrvl)
            intrvl_reg <= csr_wrdata[15:0];
         // link rise wins over a host write
         if (linkactive_rise)
         begin
            txmode_reg   <= {8'h00, phy_iow, 8'h00, 8'h11};  // crdt en + tx en
            rxmode_reg   <= {8'h00, phy_iow, 8'h00, 8'h01};  // rx en
            crdtinit_reg <= {link_tot_crdt >> phy_iow, link_tot_crdt >> phy_iow};
         end
         else
         begin
            if (csr_write && csr_offset == txmode)
               txmode_reg <= csr_wrdata;
            if (csr_write && csr_offset == rxmode)
               rxmode_reg <= csr_wrdata;
            if (csr_write && csr_offset == crdtinit)
               crdtinit_reg <= csr_wrdata;
         end
      end
   end

   // field outputs
   assign csr_arbmode          = ctrl_reg[5:4];
   assign csr_txen             = linkactive & txmode_reg[0];   // gated by link
   assign csr_txcrdt_en        = txmode_reg[4];
   assign csr_txiowidth        = txmode_reg[23:16];            // log2 bytes
   assign csr_rxen             = linkactive & rxmode_reg[0];
   assign csr_rxiowidth        = rxmode_reg[23:16];
   assign csr_txcrdt_intrvl    = intrvl_reg;
   assign csr_rxcrdt_req_init  = crdtinit_reg[15:0];
   assign csr_rxcrdt_resp_init = crdtinit_reg[31:16];

   //####################################################################
   // read mux
   //####################################################################
   // registered, data valid the cycle after csr_read
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         csr_rddata <= '0;
      else if (csr_read)
         case (csr_offset)
            ctrl        : csr_rddata <= ctrl_reg;
            status      : csr_rddata <= status_reg;
            txmode      : csr_rddata <= txmode_reg;
            rxmode      : csr_rddata <= rxmode_reg;
            crdtinit    : csr_rddata <= crdtinit_reg;
            crdtintrvl  : csr_rddata <= {16'h0000, intrvl_reg};
            req_stall   : csr_rddata <= req_stall_cycles;
            resp_stall  : csr_rddata <= resp_stall_cycles;
            req_active  : csr_rddata <= req_active_cycles;
            resp_active : csr_rddata <= resp_active_cycles;
            default     : csr_rddata <= '0;      // unmapped
         endcase
   end

endmodule

//--- design/link_req_decode.sv
/*
 * request decode stage
 * accepts one request, checks opcode and group, strobes csr for a cycle
 */
`timescale 1ns/1ps

module link_req_decode
  (
   input  logic                         clk,
   input  logic                         nreset,
   // host request channel
   input  logic                         req_valid,
   input  logic [link_pkg::link_cw-1:0] req_cmd,
   input  logic [link_pkg::link_aw-1:0] req_addr,
   output logic                         req_ready,
   // register strobes
   output logic                         csr_write,
   output logic                         csr_read,
   output logic [5:0]                   csr_offset,
   // towards the response builder
   output logic                         exec_valid,
   output link_pkg::link_opcode_e       exec_opcode,
   output logic [link_pkg::link_aw-1:0] exec_addr,
   input  logic                         resp_done
   );

   import link_pkg::*;

   link_state_e        state;
   logic [4:0]         op_q;                     // raw opcode, may be unknown
   logic [link_aw-1:0] addr_q;
   logic               grp_hit;
   logic               op_ok;

   // idle -> exec -> resp -> idle
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         state <= idle;
      else
         case (state)
            idle    : state <= req_valid ? exec : idle;
            exec    : state <= resp;             // single cycle
            resp    : state <= resp_done ? idle : resp;
            default : state <= idle;
         endcase
   end

   // capture on accept, held until the next request
   always_ff @(posedge clk)
   begin
      if (req_valid && req_ready)
      begin
         op_q   <= req_cmd[4:0];
         addr_q <= req_addr;
      end
   end

   assign req_ready  = (state == idle);
   assign exec_valid = (state == exec);

   // classification
   assign grp_hit = (addr_q[link_grp_lsb +: 8] == link_grp_id);
   assign op_ok   = (op_q == req_read) || (op_q == req_write);

   // no strobe for a miss or a bad opcode
   assign csr_write  = exec_valid & grp_hit & (op_q == req_write);
   assign csr_read   = exec_valid & grp_hit & (op_q == req_read);
   assign csr_offset = addr_q[7:2];

   assign exec_opcode = (grp_hit && op_ok) ? link_opcode_e'(op_q) : resp_error;
   assign exec_addr   = addr_q;

endmodule

//--- design/link_pkg.sv
/*
 * shared definitions for the link control block
 * bus widths, group decode, credit total, opcode/state/offset enums
 */
package link_pkg;

   //####################################################################
   // widths
   //####################################################################
   localparam int link_aw = 32;                  // request address
   localparam int link_cw = 32;                  // command word
   localparam int link_rw = 32;                  // register word

   // register group lives in the top address byte
   localparam logic [7:0] link_grp_id  = 8'h00;
   localparam int         link_grp_lsb = 24;

   // receive credits before scaling by io width
   localparam logic [15:0] link_tot_crdt = 16'd64;

   //####################################################################
   // encodings
   //####################################################################
   // low five bits of the command word
   typedef enum logic [4:0] {
      req_read   = 5'd1,
      req_write  = 5'd3,
      resp_read  = 5'd8,
      resp_write = 5'd9,
      resp_error = 5'd15
   } link_opcode_e;

   // one request in flight at a time
   typedef enum logic [1:0] {
      idle = 2'd0,                               // waiting for a request
      exec = 2'd1,                               // strobes out to csr
      resp = 2'd2                                // response pending
   } link_state_e;

   // word offsets, address bits 7:2
   typedef enum logic [5:0] {
      ctrl        = 6'd0,
      status      = 6'd1,
      txmode      = 6'd2,
      rxmode      = 6'd3,
      crdtinit    = 6'd4,
      crdtintrvl  = 6'd5,
      req_stall   = 6'd6,
      resp_stall  = 6'd7,
      req_active  = 6'd8,
      resp_active = 6'd9
   } link_csr_addr_e;

endpackage
